// File: design/dbginfo_read_pkg.sv
package dbginfo_read_pkg;

  // ======================================================================
  // read side of the debug info snapshot
  // ======================================================================

  // one chunk per register read
  localparam int CHUNK_W = 60;

  // four chunks cover the padded snapshot
  localparam int CHUNK_NUM = 4;

  // pointer walks the chunks, wraps after the last
  localparam int RPTR_W = 2;

  // cp0 register address for the debug info read
  localparam logic [11:0] DBGINFO_ADDR = 12'hfe1;

  // one slice of the padded snapshot
  typedef logic [CHUNK_W-1:0] dbginfo_chunk_t;

  // chunk index
  typedef logic [RPTR_W-1:0] dbginfo_rptr_t;

  // ======================================================================
  // 64-bit word returned to cp0
  // ======================================================================

  // layout from the top down
  //   data  : selected chunk
  //   rsvd  : tied low
  //   fresh : chunk not read since last record
  //   rptr  : index of the chunk in data
  typedef struct packed {
    dbginfo_chunk_t data;
    logic           rsvd;
    logic           fresh;
    dbginfo_rptr_t  rptr;
  } dbginfo_word_t;

endpackage

// File: design/dbginfo_unit_pkg.sv
package dbginfo_unit_pkg;

  // ======================================================================
  // per-unit debug bus widths
  // ======================================================================

  // fetch, decode, vector decode
  localparam int IFU_INFO_W  = 21;
  localparam int IDU_INFO_W  = 15;
  localparam int VIDU_INFO_W = 8;

  // load store unit is the widest
  localparam int LSU_INFO_W  = 94;

  // execute, retire, vector
  localparam int IU_INFO_W   = 9;
  localparam int RTU_INFO_W  = 15;
  localparam int VPU_INFO_W  = 29;

  // system and translation
  localparam int CP0_INFO_W  = 6;
  localparam int MMU_INFO_W  = 16;

  // recorded width, sum of the nine buses
  localparam int SNAP_W = 213;

  // padded up to four whole chunks
  localparam int SNAP_PAD_W = 240;

  // ======================================================================
  // unit buses, msb to lsb
  // ======================================================================

  // ifu sits at bit 0
  typedef struct packed {
    logic [MMU_INFO_W-1:0]  mmu;
    logic [CP0_INFO_W-1:0]  cp0;
    logic [VPU_INFO_W-1:0]  vpu;
    logic [RTU_INFO_W-1:0]  rtu;
    logic [IU_INFO_W-1:0]   iu;
    logic [LSU_INFO_W-1:0]  lsu;
    logic [VIDU_INFO_W-1:0] vidu;
    logic [IDU_INFO_W-1:0]  idu;
    logic [IFU_INFO_W-1:0]  ifu;
  } dbginfo_units_t;

  // unit view, zero pad above the recorded bits
  typedef struct packed {
    logic [SNAP_PAD_W-SNAP_W-1:0] pad;
    dbginfo_units_t               units;
  } dbginfo_snap_units_t;

  // ======================================================================
  // padded snapshot
  // ======================================================================

  // written as units, read back as chunks
  // chunk i covers bits 60i+59 down to 60i
  typedef union packed {
    dbginfo_snap_units_t unit_view;
    dbginfo_read_pkg::dbginfo_chunk_t [dbginfo_read_pkg::CHUNK_NUM-1:0] chunk_view;
  } dbginfo_snap_u;

endpackage

// File: design/dbginfo_capture.sv
`timescale 1ns/1ps

module dbginfo_capture (
  input  logic                            dbginfo_clk,
  input  logic                            cpurst_b,
  input  logic                            dtu_rtu_async_halt_req,
  input  dbginfo_unit_pkg::dbginfo_units_t units,
  output dbginfo_unit_pkg::dbginfo_snap_u  snap,
  output logic                            record
);

  // previous halt request level
  logic halt_q;

  // ======================================================================
  // halt edge detect
  // ======================================================================

  // cleared by reset, so a halt held through reset
  // still records on the first cycle
  always_ff @(posedge dbginfo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      halt_q <= 1'b0;
    end
    else
    begin
      halt_q <= dtu_rtu_async_halt_req;
    end
  end

  // one cycle on the rising edge only
  // a held halt keeps the first snapshot
  assign record = dtu_rtu_async_halt_req && !halt_q;

  // ======================================================================
  // snapshot assembly
  // ======================================================================

  // unit order fixed by the struct, ifu at bit 0
  // pad bits above the units are zero
  always_comb
  begin
    snap.unit_view.pad   = '0;
    snap.unit_view.units = units;
  end

endmodule

// File: design/dbginfo_chunk.sv
`timescale 1ns/1ps

module dbginfo_chunk (
  input  logic                             dbginfo_clk,
  input  logic                             cpurst_b,
  input  logic                             record,
  input  dbginfo_read_pkg::dbginfo_chunk_t chunk_in,
  input  logic                             rd_hit,
  output dbginfo_read_pkg::dbginfo_chunk_t chunk,
  output logic                             fresh
);

  // ======================================================================
  // chunk data
  // ======================================================================

  // reset to zero so an unrecorded read returns zero
  always_ff @(posedge dbginfo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      chunk <= '0;
    end
    else if (record)
    begin
      chunk <= chunk_in;
    end
  end

  // ======================================================================
  // fresh flag
  // ======================================================================

  // set on record
  // cleared when this chunk is read
  // record beats a read in the same cycle
  always_ff @(posedge dbginfo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      fresh <= 1'b0;
    end
    else if (record)
    begin
      fresh <= 1'b1;
    end
    else if (rd_hit)
    begin
      fresh <= 1'b0;
    end
  end

endmodule

// File: design/dbginfo_readout.sv
`timescale 1ns/1ps

module dbginfo_readout (
  input  logic                             dbginfo_clk,
  input  logic                             cpurst_b,
  input  logic                             cp0_dtu_rreg,
  input  logic [11:0]                      cp0_dtu_addr,
  input  dbginfo_read_pkg::dbginfo_chunk_t chunks [dbginfo_read_pkg::CHUNK_NUM],
  input  logic [dbginfo_read_pkg::CHUNK_NUM-1:0] fresh,
  output logic [dbginfo_read_pkg::CHUNK_NUM-1:0] rd_hit,
  output dbginfo_read_pkg::dbginfo_word_t  dbgfifo_regs_data
);

  // register read hit this cycle
  logic                            rd_dbginfo;
  // chunk selected for the next read
  dbginfo_read_pkg::dbginfo_rptr_t rptr;

  // ======================================================================
  // read decode
  // ======================================================================

  // plain strobe, no handshake
  assign rd_dbginfo = cp0_dtu_rreg && (cp0_dtu_addr == dbginfo_read_pkg::DBGINFO_ADDR);

  // one-hot at the pointer, only on a read
  always_comb
  begin
    for (int i = 0; i < dbginfo_read_pkg::CHUNK_NUM; i++)
    begin
      rd_hit[i] = rd_dbginfo && (rptr == i[dbginfo_read_pkg::RPTR_W-1:0]);
    end
  end

  // ======================================================================
  // read pointer
  // ======================================================================

  // advances per read, wraps naturally after chunk 3
  always_ff @(posedge dbginfo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rptr <= '0;
    end
    else if (rd_dbginfo)
    begin
      rptr <= rptr + 1'b1;
    end
  end

  // ======================================================================
  // read word
  // ======================================================================

  // combinational from the current pointer
  // word seen in the read cycle is the one returned
  always_comb
  begin
    dbgfifo_regs_data.data  = chunks[rptr];
    dbgfifo_regs_data.rsvd  = 1'b0;
    dbgfifo_regs_data.fresh = fresh[rptr];
    dbgfifo_regs_data.rptr  = rptr;
  end

endmodule

// File: design/dbginfo_top.sv
`timescale 1ns/1ps

module dbginfo_top (
  input  logic                            dbginfo_clk,
  input  logic                            cpurst_b,
  input  logic                            dtu_rtu_async_halt_req,
  input  logic                            cp0_dtu_rreg,
  input  logic [11:0]                     cp0_dtu_addr,
  input  dbginfo_unit_pkg::dbginfo_units_t units,
  output dbginfo_read_pkg::dbginfo_word_t dbgfifo_regs_data
);

  // padded snapshot from capture
  dbginfo_unit_pkg::dbginfo_snap_u  snap;
  // halt rising edge
  logic                             record;
  // held chunks toward readout
  dbginfo_read_pkg::dbginfo_chunk_t chunks [dbginfo_read_pkg::CHUNK_NUM];
  // per-chunk fresh flags
  logic [dbginfo_read_pkg::CHUNK_NUM-1:0] fresh;
  // per-chunk read strobes
  logic [dbginfo_read_pkg::CHUNK_NUM-1:0] rd_hit;

  // ======================================================================
  // capture
  // ======================================================================

  dbginfo_capture capture_i (
    .dbginfo_clk            (dbginfo_clk),
    .cpurst_b               (cpurst_b),
    .dtu_rtu_async_halt_req (dtu_rtu_async_halt_req),
    .units                  (units),
    .snap                   (snap),
    .record                 (record)
  );

  // ======================================================================
  // chunk holders
  // ======================================================================

  // holder i takes bits 60i+59 down to 60i
  for (genvar i = 0; i < dbginfo_read_pkg::CHUNK_NUM; i++)
  begin : gen_chunk
    dbginfo_chunk chunk_i (
      .dbginfo_clk (dbginfo_clk),
      .cpurst_b    (cpurst_b),
      .record      (record),
      .chunk_in    (snap.chunk_view[i]),
      .rd_hit      (rd_hit[i]),
      .chunk       (chunks[i]),
      .fresh       (fresh[i])
    );
  end

  // ======================================================================
  // readout
  // ======================================================================

  dbginfo_readout readout_i (
    .dbginfo_clk       (dbginfo_clk),
    .cpurst_b          (cpurst_b),
    .cp0_dtu_rreg      (cp0_dtu_rreg),
    .cp0_dtu_addr      (cp0_dtu_addr),
    .chunks            (chunks),
    .fresh             (fresh),
    .rd_hit            (rd_hit),
    .dbgfifo_regs_data (dbgfifo_regs_data)
  );

endmodule

// File: test/dbginfo_clkgen.sv
`timescale 1ns/1ps

module dbginfo_clkgen (
  output logic dbginfo_clk,
  output logic cpurst_b
);

  // free-running 10 ns clock
  initial
  begin
    dbginfo_clk = 1'b0;
    forever
    begin
      #5 dbginfo_clk = ~dbginfo_clk;
    end
  end

  // reset low for the first 10 rising edges
  // released just after an edge, away from the sampling point
  initial
  begin
    cpurst_b = 1'b0;
    repeat (10) @(posedge dbginfo_clk);
    #1 cpurst_b = 1'b1;
  end

endmodule

// File: test/dbginfo_assert.sv
`timescale 1ns/1ps

module dbginfo_assert (
  input logic                                   dbginfo_clk,
  input logic                                   cpurst_b,
  input logic                                   cp0_dtu_rreg,
  input logic [11:0]                            cp0_dtu_addr,
  input logic                                   record,
  input logic [dbginfo_read_pkg::CHUNK_NUM-1:0] fresh,
  input dbginfo_read_pkg::dbginfo_word_t        dbgfifo_regs_data
);

  // register read seen at the top ports
  logic rd_dbginfo;

  assign rd_dbginfo = cp0_dtu_rreg && (cp0_dtu_addr == dbginfo_read_pkg::DBGINFO_ADDR);

  // reserved bit never set
  rsvd_zero_a: assert property (
    @(posedge dbginfo_clk) disable iff (!cpurst_b)
      dbgfifo_regs_data.rsvd == 1'b0
  )
  else $error("reserved bit of the read word is set");

  // pointer only moves on the edge ending a read cycle
  rptr_step_a: assert property (
    @(posedge dbginfo_clk) disable iff (!cpurst_b)
      (dbgfifo_regs_data.rptr != $past(dbgfifo_regs_data.rptr)) |-> $past(rd_dbginfo)
  )
  else $error("read pointer moved without a read");

  // record sets every fresh flag, even with a read in the same cycle
  fresh_set_a: assert property (
    @(posedge dbginfo_clk) disable iff (!cpurst_b)
      $past(record) |-> (fresh == '1)
  )
  else $error("fresh flags not all set after a record");

endmodule

bind dbginfo_top dbginfo_assert assert_i (
  .dbginfo_clk       (dbginfo_clk),
  .cpurst_b          (cpurst_b),
  .cp0_dtu_rreg      (cp0_dtu_rreg),
  .cp0_dtu_addr      (cp0_dtu_addr),
  .record            (record),
  .fresh             (fresh),
  .dbgfifo_regs_data (dbgfifo_regs_data)
);

// File: test/dbginfo_tb.sv
`timescale 1ns/1ps

module dbginfo_tb;

  // ======================================================================
  // dut connections
  // ======================================================================

  logic                             dbginfo_clk;
  logic                             cpurst_b;
  logic                             dtu_rtu_async_halt_req;
  logic                             cp0_dtu_rreg;
  logic [11:0]                      cp0_dtu_addr;
  dbginfo_unit_pkg::dbginfo_units_t units;
  dbginfo_read_pkg::dbginfo_word_t  dbgfifo_regs_data;

  // fixed seed for the unit buses
  integer seed = 32'ha899d011;

  // model of the stored snapshot, flags and pointer
  dbginfo_unit_pkg::dbginfo_units_t       model_units;
  logic [dbginfo_read_pkg::CHUNK_NUM-1:0] model_fresh;
  dbginfo_read_pkg::dbginfo_rptr_t        model_rptr;
  logic                                   model_halt_q;

  // handed from stimulus to the compare process
  logic                             chk_valid;
  string                            chk_name;
  dbginfo_read_pkg::dbginfo_word_t  exp_word;
  dbginfo_read_pkg::dbginfo_chunk_t exp_chunk;

  // one snapshot per scenario
  dbginfo_unit_pkg::dbginfo_units_t units_a;
  dbginfo_unit_pkg::dbginfo_units_t units_b;
  dbginfo_unit_pkg::dbginfo_units_t units_c;
  dbginfo_unit_pkg::dbginfo_units_t units_d;

  dbginfo_clkgen clkgen_i (
    .dbginfo_clk (dbginfo_clk),
    .cpurst_b    (cpurst_b)
  );

  dbginfo_top dut_i (
    .dbginfo_clk            (dbginfo_clk),
    .cpurst_b               (cpurst_b),
    .dtu_rtu_async_halt_req (dtu_rtu_async_halt_req),
    .cp0_dtu_rreg           (cp0_dtu_rreg),
    .cp0_dtu_addr           (cp0_dtu_addr),
    .units                  (units),
    .dbgfifo_regs_data      (dbgfifo_regs_data)
  );

  // ======================================================================
  // failure and compare tasks
  // ======================================================================

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(
    input string                           name,
    input dbginfo_read_pkg::dbginfo_word_t expected,
    input dbginfo_read_pkg::dbginfo_word_t actual
  );
    if (actual !== expected)
    begin
      stop_on_failure($sformatf("[ERROR] %s word: expected %h actual %h",
                                name, expected, actual));
    end
  endtask

  task automatic check_chunk(
    input string                            name,
    input dbginfo_read_pkg::dbginfo_chunk_t expected,
    input dbginfo_read_pkg::dbginfo_chunk_t actual
  );
    if (actual !== expected)
    begin
      stop_on_failure($sformatf("[ERROR] %s chunk: expected %h actual %h",
                                name, expected, actual));
    end
  endtask

  // ======================================================================
  // reference and model
  // ======================================================================

  // pad above the units, then slice 60 bits per index
  function automatic dbginfo_read_pkg::dbginfo_chunk_t ref_chunk(
    input dbginfo_unit_pkg::dbginfo_units_t u,
    input int                               idx
  );
    logic [239:0] padded;
    padded = {27'b0, u};
    return padded[idx*60 +: 60];
  endfunction

  // word the dut should present right now
  function automatic dbginfo_read_pkg::dbginfo_word_t model_word();
    dbginfo_read_pkg::dbginfo_word_t w;
    w.data  = ref_chunk(model_units, int'(model_rptr));
    w.rsvd  = 1'b0;
    w.fresh = model_fresh[model_rptr];
    w.rptr  = model_rptr;
    return w;
  endfunction

  // state after the coming edge
  task automatic update_model(
    input logic                             halt,
    input logic                             rd,
    input dbginfo_unit_pkg::dbginfo_units_t new_units
  );
    logic rec;
    rec = halt && !model_halt_q;
    // clear at the old pointer unless record wins
    if (rd)
    begin
      if (!rec)
      begin
        model_fresh[model_rptr] = 1'b0;
      end
      model_rptr = model_rptr + 1'b1;
    end
    if (rec)
    begin
      model_units = new_units;
      model_fresh = '1;
    end
    model_halt_q = halt;
  endtask

  task automatic rand_units(output dbginfo_unit_pkg::dbginfo_units_t u);
    logic [223:0] raw;
    raw = '0;
    for (int k = 0; k < 7; k++)
    begin
      raw = {raw[191:0], $random(seed)};
    end
    u = raw[212:0];
  endtask

  // ======================================================================
  // stimulus
  // ======================================================================

  // called 1 ns after a rising edge, returns 1 ns after the next
  task automatic drive_cycle(
    input string                            name,
    input logic                             halt,
    input logic                             rreg,
    input logic [11:0]                      addr,
    input dbginfo_unit_pkg::dbginfo_units_t u
  );
    dtu_rtu_async_halt_req = halt;
    cp0_dtu_rreg           = rreg;
    cp0_dtu_addr           = addr;
    units                  = u;
    exp_word               = model_word();
    exp_chunk              = ref_chunk(model_units, int'(model_rptr));
    chk_name               = name;
    // reads and near misses get compared
    chk_valid = rreg || (addr == 12'hfe1);
    update_model(halt, rreg && (addr == 12'hfe1), u);
    @(posedge dbginfo_clk);
    #1;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (!cpurst_b && n < 20)
    begin
      @(posedge dbginfo_clk);
      n++;
    end
    #1;
    if (!cpurst_b)
    begin
      stop_on_failure("reset was never released");
    end
  endtask

  // idle cycles until the selected chunk shows fresh
  task automatic wait_fresh(input string name);
    int n;
    n = 0;
    while (!dbgfifo_regs_data.fresh && n < 8)
    begin
      drive_cycle(name, dtu_rtu_async_halt_req, 1'b0, 12'h000, units);
      n++;
    end
    if (!dbgfifo_regs_data.fresh)
    begin
      stop_on_failure($sformatf("%s: fresh flag did not rise after the halt edge", name));
    end
  endtask

  // ======================================================================
  // compare process, mid-cycle when the word is settled
  // ======================================================================

  always @(negedge dbginfo_clk)
  begin
    if (chk_valid)
    begin
      check_chunk(chk_name, exp_chunk, dbgfifo_regs_data.data);
      check_word(chk_name, exp_word, dbgfifo_regs_data);
    end
  end

  // hard limit on the whole run
  initial
  begin
    #100000;
    stop_on_failure("simulation did not finish within its time limit");
  end

  initial
  begin
    dtu_rtu_async_halt_req = 1'b0;
    cp0_dtu_rreg           = 1'b0;
    cp0_dtu_addr           = '0;
    units                  = '0;
    chk_valid              = 1'b0;
    chk_name               = "idle";
    exp_word               = '0;
    exp_chunk              = '0;
    model_units            = '0;
    model_fresh            = '0;
    model_rptr             = '0;
    model_halt_q           = 1'b0;

    wait_reset_release();

    // all zero out of reset
    check_word("reset_zero", '0, dbgfifo_regs_data);

    // halt edge, one pass over chunks 0 to 3, all fresh
    rand_units(units_a);
    drive_cycle("halt_rise", 1'b1, 1'b0, 12'h000, units_a);
    wait_fresh("halt_rise");
    for (int k = 0; k < 4; k++)
    begin
      drive_cycle("first_pass", 1'b1, 1'b1, 12'hfe1, units_a);
    end

    // held halt ignores new bus values, pointer wraps, fresh gone
    rand_units(units_b);
    drive_cycle("halt_held", 1'b1, 1'b0, 12'h000, units_b);
    drive_cycle("halt_held", 1'b1, 1'b0, 12'h000, units_b);
    for (int k = 0; k < 4; k++)
    begin
      drive_cycle("second_pass", 1'b1, 1'b1, 12'hfe1, units_b);
    end

    // near misses keep pointer and fresh
    rand_units(units_c);
    drive_cycle("halt_drop", 1'b0, 1'b0, 12'h000, units_c);
    drive_cycle("halt_rise_c", 1'b1, 1'b0, 12'h000, units_c);
    wait_fresh("halt_rise_c");
    drive_cycle("wrong_addr", 1'b1, 1'b1, 12'hfe0, units_c);
    drive_cycle("no_strobe", 1'b1, 1'b0, 12'hfe1, units_c);
    drive_cycle("read_after_miss", 1'b1, 1'b1, 12'hfe1, units_c);
    drive_cycle("wrong_addr", 1'b1, 1'b1, 12'hfe2, units_c);
    drive_cycle("no_strobe", 1'b1, 1'b0, 12'hfe1, units_c);
    drive_cycle("read_after_miss", 1'b1, 1'b1, 12'hfe1, units_c);

    // record and read together at pointer 2
    rand_units(units_d);
    drive_cycle("halt_drop", 1'b0, 1'b0, 12'h000, units_d);
    drive_cycle("record_read", 1'b1, 1'b1, 12'hfe1, units_d);
    for (int k = 0; k < 4; k++)
    begin
      drive_cycle("after_record_read", 1'b1, 1'b1, 12'hfe1, units_d);
    end
    drive_cycle("idle", 1'b1, 1'b0, 12'h000, units_d);

    $display("all tests passed");
    $finish;
  end

endmodule

// File: sources.f
design/dbginfo_read_pkg.sv
design/dbginfo_unit_pkg.sv
design/dbginfo_capture.sv
design/dbginfo_chunk.sv
design/dbginfo_readout.sv
design/dbginfo_top.sv
test/dbginfo_clkgen.sv
test/dbginfo_assert.sv
test/dbginfo_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the debug info testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f sources.f \
  --top-module dbginfo_tb \
  -Mdir obj_dir \
  -o dbginfo_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/dbginfo_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
